// ==== files.f ====
+incdir+include
rtl/core_pkg.sv
rtl/fetch_stage.sv
rtl/decode_stage.sv
rtl/reg_file.sv
rtl/exec_stage.sv
rtl/rv_core.sv
tests/rv_core_chk.sv
tests/rv_core_tb.sv

// ==== include/core_defs.svh ====
`ifndef CORE_DEFS_SVH
`define CORE_DEFS_SVH

// datapath and register index widths
`define XLEN            64
`define REG_AW          5

// fetch address after reset and sequential step
`define RESET_PC        32'h8000_0000
`define PC_STEP         4

// major opcodes accepted by decode
`define OPC_OP          7'b0110011
`define OPC_OP_IMM      7'b0010011

// funct3 per alu operation, shared by r and i forms
`define F3_ADD          3'b000
`define F3_SLL          3'b001
`define F3_SLT          3'b010
`define F3_XOR          3'b100
`define F3_SRL          3'b101
`define F3_OR           3'b110
`define F3_AND          3'b111

// funct7 values, alt selects sub
`define FUNCT7_BASE     7'h00
`define FUNCT7_ALT      7'h20

`endif

// ==== rtl/core_pkg.sv ====
`include "core_defs.svh"

package core_pkg;

    // ********************************************************
    // instruction word views
    // ********************************************************

    typedef struct packed {
        logic [6:0]         funct7;
        logic [4:0]         rs2;
        logic [4:0]         rs1;
        logic [2:0]         funct3;
        logic [4:0]         rd;
        logic [6:0]         opcode;
    } inst_r_t;

    typedef struct packed {
        logic [11:0]        imm12;
        logic [4:0]         rs1;
        logic [2:0]         funct3;
        logic [4:0]         rd;
        logic [6:0]         opcode;
    } inst_i_t;

    // same 32 bits, decoded as r or i form
    typedef union packed {
        inst_r_t            r;
        inst_i_t            i;
    } inst_u;

    typedef enum logic [3:0] {
        add,
        sub,
        sll,
        slt,
        xor_op,
        srl,
        or_op,
        and_op
    } alu_op_e;

    // ********************************************************
    // pipeline records
    // ********************************************************

    typedef struct packed {
        logic               valid;
        logic [`XLEN-1:0]   pc;
        inst_u              inst;
    } if_id_t;

    typedef struct packed {
        logic               valid;
        logic               reg_we;
        logic [`REG_AW-1:0] rd;
        alu_op_e            alu_op;
        logic [`XLEN-1:0]   op1;
        logic [`XLEN-1:0]   op2;
    } id_ex_t;

    typedef struct packed {
        logic               we;
        logic [`REG_AW-1:0] waddr;
        logic [`XLEN-1:0]   wdata;
    } wb_t;

endpackage

// ==== rtl/decode_stage.sv ====
`timescale 1ns/1ps
`include "core_defs.svh"

module decode_stage (
    input  logic                clk,
    input  logic                rst_n,
    input  core_pkg::if_id_t    if_id_i,
    input  logic [`XLEN-1:0]    rdata1_i,
    input  logic [`XLEN-1:0]    rdata2_i,
    output logic [`REG_AW-1:0]  raddr1_o,
    output logic [`REG_AW-1:0]  raddr2_o,
    output core_pkg::id_ex_t    id_ex_o
);
    import core_pkg::*;

    inst_u              inst;
    logic [`XLEN-1:0]   imm_sext;
    logic [`XLEN-1:0]   imm_shamt;
    logic               known;
    id_ex_t             id_ex_d;

    assign inst = if_id_i.inst;

    // rs1/rs2 sit at the same bits in both forms
    assign raddr1_o = inst.r.rs1;
    assign raddr2_o = inst.r.rs2;

    assign imm_sext  = {{(`XLEN-12){inst.i.imm12[11]}}, inst.i.imm12};
    assign imm_shamt = {{(`XLEN-6){1'b0}}, inst.i.imm12[5:0]};

    // ********************************************************
    // decode
    // ********************************************************

    always_comb begin
        known          = 1'b0;
        id_ex_d.alu_op = add;
        id_ex_d.op1    = rdata1_i;
        id_ex_d.op2    = rdata2_i;
        case (inst.r.opcode)
            `OPC_OP: begin
                // only sub may use the alt funct7
                known = (inst.r.funct7 == `FUNCT7_BASE) ||
                        (inst.r.funct7 == `FUNCT7_ALT && inst.r.funct3 == `F3_ADD);
                case (inst.r.funct3)
                    `F3_ADD: id_ex_d.alu_op = (inst.r.funct7 == `FUNCT7_ALT) ? sub : add;
                    `F3_SLL: id_ex_d.alu_op = sll;
                    `F3_SLT: id_ex_d.alu_op = slt;
                    `F3_XOR: id_ex_d.alu_op = xor_op;
                    `F3_SRL: id_ex_d.alu_op = srl;
                    `F3_OR:  id_ex_d.alu_op = or_op;
                    `F3_AND: id_ex_d.alu_op = and_op;
                    default: known = 1'b0;
                endcase
            end
            `OPC_OP_IMM: begin
                known       = 1'b1;
                id_ex_d.op2 = imm_sext;
                case (inst.i.funct3)
                    `F3_ADD: id_ex_d.alu_op = add;
                    `F3_SLT: id_ex_d.alu_op = slt;
                    `F3_XOR: id_ex_d.alu_op = xor_op;
                    `F3_OR:  id_ex_d.alu_op = or_op;
                    `F3_AND: id_ex_d.alu_op = and_op;
                    `F3_SLL: begin
                        id_ex_d.alu_op = sll;
                        id_ex_d.op2    = imm_shamt;
                        known          = (inst.i.imm12[11:6] == 6'd0);
                    end
                    // srai has upper bits set and is not supported
                    `F3_SRL: begin
                        id_ex_d.alu_op = srl;
                        id_ex_d.op2    = imm_shamt;
                        known          = (inst.i.imm12[11:6] == 6'd0);
                    end
                    default: known = 1'b0;
                endcase
            end
            default: known = 1'b0;
        endcase

        // anything unknown turns into a bubble
        id_ex_d.valid  = if_id_i.valid & known;
        id_ex_d.reg_we = id_ex_d.valid & (inst.r.rd != '0);
        id_ex_d.rd     = inst.r.rd;
    end

    // ID/EX register
    always_ff @(posedge clk) begin
        id_ex_o <= id_ex_d;
        if (rst_n) begin
            id_ex_o.valid  <= 1'b0;
            id_ex_o.reg_we <= 1'b0;
        end
    end

endmodule

// ==== rtl/exec_stage.sv ====
`timescale 1ns/1ps
`include "core_defs.svh"

module exec_stage (
    input  core_pkg::id_ex_t    id_ex_i,
    output core_pkg::wb_t       wb_o
);
    import core_pkg::*;

    logic [`XLEN-1:0]   op1;
    logic [`XLEN-1:0]   op2;
    logic [5:0]         shamt;
    logic               lt;
    logic [`XLEN-1:0]   result;

    assign op1 = id_ex_i.op1;
    assign op2 = id_ex_i.op2;

    // rv64 shifts use six bits of the amount
    assign shamt = op2[5:0];

    assign lt = $signed(op1) < $signed(op2);

    // ********************************************************
    // ALU
    // ********************************************************

    always_comb begin
        case (id_ex_i.alu_op)
            add:     result = op1 + op2;
            sub:     result = op1 - op2;
            sll:     result = op1 << shamt;
            slt:     result = {{(`XLEN-1){1'b0}}, lt};
            xor_op:  result = op1 ^ op2;
            srl:     result = op1 >> shamt;
            or_op:   result = op1 | op2;
            and_op:  result = op1 & op2;
            default: result = '0;
        endcase
    end

    // ********************************************************
    // writeback record
    // ********************************************************

    // bubbles never write
    assign wb_o.we    = id_ex_i.valid & id_ex_i.reg_we;
    assign wb_o.waddr = id_ex_i.rd;
    assign wb_o.wdata = result;

endmodule

// ==== rtl/fetch_stage.sv ====
`timescale 1ns/1ps
`include "core_defs.svh"

module fetch_stage (
    input  logic                clk,
    input  logic                rst_n,
    input  logic [31:0]         inst_i,
    output logic [`XLEN-1:0]    pc_o,
    output core_pkg::if_id_t    if_id_o
);
    import core_pkg::*;

    // ********************************************************
    // program counter, strictly sequential
    // ********************************************************

    always_ff @(posedge clk) begin
        if (rst_n) begin
            pc_o <= `XLEN'(`RESET_PC);
        end else begin
            pc_o <= pc_o + `XLEN'(`PC_STEP);
        end
    end

    // ********************************************************
    // IF/ID register
    // ********************************************************

    // inst_i belongs to the current pc_o
    always_ff @(posedge clk) begin
        if_id_o.pc    <= pc_o;
        if_id_o.inst  <= inst_u'(inst_i);
        if_id_o.valid <= 1'b1;
        if (rst_n) begin
            if_id_o.valid <= 1'b0;
        end
    end

endmodule

// ==== rtl/reg_file.sv ====
`timescale 1ns/1ps
`include "core_defs.svh"

module reg_file (
    input  logic                clk,
    input  core_pkg::wb_t       wb_i,
    input  logic [`REG_AW-1:0]  raddr1_i,
    input  logic [`REG_AW-1:0]  raddr2_i,
    output logic [`XLEN-1:0]    rdata1_o,
    output logic [`XLEN-1:0]    rdata2_o
);

    // x0 has no storage
    logic [`XLEN-1:0] regs [1:31];

    // ********************************************************
    // write port
    // ********************************************************

    always_ff @(posedge clk) begin
        if (wb_i.we && wb_i.waddr != '0) begin
            regs[wb_i.waddr] <= wb_i.wdata;
        end
    end

    // ********************************************************
    // read ports
    // ********************************************************

    // write-through, so a dependent instruction right behind
    // the writer sees the new value
    function automatic logic [`XLEN-1:0] read_port(input logic [`REG_AW-1:0] addr);
        if (addr == '0) begin
            return '0;
        end else if (wb_i.we && wb_i.waddr == addr) begin
            return wb_i.wdata;
        end else begin
            return regs[addr];
        end
    endfunction

    always_comb begin
        rdata1_o = read_port(raddr1_i);
        rdata2_o = read_port(raddr2_i);
    end

endmodule

// ==== rtl/rv_core.sv ====
`timescale 1ns/1ps
`include "core_defs.svh"

module rv_core (
    input  logic                clk,
    input  logic                rst_n,
    input  logic [31:0]         inst_i,
    output logic [`XLEN-1:0]    pc_o,
    output logic                wb_valid_o,
    output logic [`REG_AW-1:0]  wb_addr_o,
    output logic [`XLEN-1:0]    wb_data_o
);
    import core_pkg::*;

    if_id_t             if_id;
    id_ex_t             id_ex;
    wb_t                wb;
    logic [`REG_AW-1:0] raddr1;
    logic [`REG_AW-1:0] raddr2;
    logic [`XLEN-1:0]   rdata1;
    logic [`XLEN-1:0]   rdata2;

    fetch_stage u_fetch (
        .clk        (clk),
        .rst_n      (rst_n),
        .inst_i     (inst_i),
        .pc_o       (pc_o),
        .if_id_o    (if_id)
    );

    decode_stage u_decode (
        .clk        (clk),
        .rst_n      (rst_n),
        .if_id_i    (if_id),
        .rdata1_i   (rdata1),
        .rdata2_i   (rdata2),
        .raddr1_o   (raddr1),
        .raddr2_o   (raddr2),
        .id_ex_o    (id_ex)
    );

    reg_file u_regs (
        .clk        (clk),
        .wb_i       (wb),
        .raddr1_i   (raddr1),
        .raddr2_i   (raddr2),
        .rdata1_o   (rdata1),
        .rdata2_o   (rdata2)
    );

    exec_stage u_exec (
        .id_ex_i    (id_ex),
        .wb_o       (wb)
    );

    // writeback also leaves the core for observation
    assign wb_valid_o = wb.we;
    assign wb_addr_o  = wb.waddr;
    assign wb_data_o  = wb.wdata;

endmodule

// ==== run.sh ====
#!/usr/bin/env bash
# build with Verilator, run, and look for the pass line in the output
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f files.f \
    --top-module rv_core_tb -o rv_core_sim || exit 1

sim_out="$(./obj_dir/rv_core_sim)"
echo "$sim_out"
echo "$sim_out" | grep -qxF "Verification passed" && exit 0 || exit 1

// ==== tests/rv_core_chk.sv ====
`timescale 1ns/1ps
`include "core_defs.svh"

module rv_core_chk (
    input  logic                clk,
    input  logic                rst_n,
    input  logic [`XLEN-1:0]    pc_i,
    input  logic                wb_valid_i,
    input  logic [`REG_AW-1:0]  wb_addr_i,
    input  logic [`XLEN-1:0]    wb_data_i
);

    int unsigned    fail_count = 0;
    logic           reset_seen = 1'b0;

    // pc history is meaningless before the first reset edge
    always @(posedge clk) begin
        if (rst_n) begin
            reset_seen <= 1'b1;
        end
    end

    // ********************************************************
    // writeback quiet during reset and two cycles after it
    // ********************************************************

    a_wb_quiet_next: assert property (@(posedge clk) rst_n |=> !wb_valid_i)
        else begin
            $error("wb_valid_o high in the first cycle after a reset edge");
            fail_count++;
        end

    a_wb_quiet_second: assert property (@(posedge clk) $past(rst_n, 2) |-> !wb_valid_i)
        else begin
            $error("wb_valid_o high in the second cycle after a reset edge");
            fail_count++;
        end

    // sequential fetch
    a_pc_step: assert property (@(posedge clk)
        reset_seen && !$past(rst_n) |-> pc_i == $past(pc_i) + `XLEN'(`PC_STEP))
        else begin
            $error("pc_o did not advance by one step");
            fail_count++;
        end

    a_wb_no_x0: assert property (@(posedge clk) wb_valid_i |-> wb_addr_i != '0)
        else begin
            $error("writeback to x0 reported on wb_addr_o");
            fail_count++;
        end

    a_wb_known: assert property (@(posedge clk) wb_valid_i |-> !$isunknown(wb_data_i))
        else begin
            $error("wb_data_o has unknown bits during a writeback");
            fail_count++;
        end

endmodule

bind rv_core rv_core_chk chk0 (
    .clk        (clk),
    .rst_n      (rst_n),
    .pc_i       (pc_o),
    .wb_valid_i (wb_valid_o),
    .wb_addr_i  (wb_addr_o),
    .wb_data_i  (wb_data_o)
);

// ==== tests/rv_core_tb.sv ====
`timescale 1ns/1ps
`include "core_defs.svh"

module rv_core_tb;
    import core_pkg::*;

    localparam int CLK_PERIOD   = 100;
    localparam int ROM_DEPTH    = 64;
    localparam int RESET_CYCLES = 2;
    localparam int DRAIN_CYCLES = 2;
    localparam int NUM_TESTS    = 6;
    localparam int RANDOM_COUNT = 40;
    localparam int MARGIN       = 20;
    // each test runs at most one full ROM
    localparam int WATCHDOG_CYCLES =
        NUM_TESTS * (RESET_CYCLES + ROM_DEPTH + DRAIN_CYCLES) + MARGIN;

    logic               clk;
    logic               rst_n;
    logic [31:0]        inst_i;
    logic [`XLEN-1:0]   pc_o;
    logic               wb_valid_o;
    logic [`REG_AW-1:0] wb_addr_o;
    logic [`XLEN-1:0]   wb_data_o;

    logic [31:0]        rom [0:ROM_DEPTH-1];
    int                 prog_len;
    logic [`XLEN-1:0]   model_regs [0:31];
    wb_t                expect_q [$];
    int                 errors;
    int                 checks;
    int                 assert_fails;
    int                 seed;

    rv_core dut0 (
        .clk        (clk),
        .rst_n      (rst_n),
        .inst_i     (inst_i),
        .pc_o       (pc_o),
        .wb_valid_o (wb_valid_o),
        .wb_addr_o  (wb_addr_o),
        .wb_data_o  (wb_data_o)
    );

    initial clk = 1'b0;
    always #(CLK_PERIOD / 2) clk = ~clk;

    initial begin
        #(WATCHDOG_CYCLES * CLK_PERIOD);
        $display("timeout: tests still running after %0d cycles", WATCHDOG_CYCLES);
        $display("Verification failed");
        $finish;
    end

    // ********************************************************
    // instruction ROM and encoders
    // ********************************************************

    task automatic clear_rom();
        for (int a = 0; a < ROM_DEPTH; a++) begin
            rom[6'(a)] = 32'h0;
        end
        prog_len = 0;
    endtask

    task automatic add_inst(input logic [31:0] word);
        rom[6'(prog_len)] = word;
        prog_len++;
    endtask

    function automatic logic [31:0] enc_r(input logic [6:0] f7, input logic [2:0] f3,
                                          input logic [4:0] rd, input logic [4:0] rs1,
                                          input logic [4:0] rs2);
        return {f7, rs2, rs1, f3, rd, `OPC_OP};
    endfunction

    function automatic logic [31:0] enc_i(input logic [2:0] f3, input logic [4:0] rd,
                                          input logic [4:0] rs1, input logic [11:0] imm);
        return {imm, rs1, f3, rd, `OPC_OP_IMM};
    endfunction

    // words outside the program read as zero, which decodes to a bubble
    function automatic logic [31:0] rom_word(input logic [`XLEN-1:0] pc);
        logic [`XLEN-1:0] offset;
        offset = pc - `XLEN'(`RESET_PC);
        if (offset[1:0] == 2'b00 && offset < `XLEN'(ROM_DEPTH * 4)) begin
            return rom[offset[7:2]];
        end
        return 32'h0;
    endfunction

    // ********************************************************
    // reference model in program order
    // ********************************************************

    function automatic wb_t predict(input logic [31:0] w);
        logic [6:0]         opc;
        logic [2:0]         f3;
        logic [6:0]         f7;
        logic [4:0]         rd;
        logic [`XLEN-1:0]   a;
        logic [`XLEN-1:0]   b;
        logic [5:0]         amt;
        logic               ok;
        logic [`XLEN-1:0]   res;
        wb_t                wb;
        opc = w[6:0];
        rd  = w[11:7];
        f3  = w[14:12];
        f7  = w[31:25];
        a   = model_regs[w[19:15]];
        b   = '0;
        amt = '0;
        ok  = 1'b0;
        if (opc == `OPC_OP) begin
            b   = model_regs[w[24:20]];
            amt = b[5:0];
            ok  = (f7 == `FUNCT7_BASE && f3 != 3'b011) ||
                  (f7 == `FUNCT7_ALT && f3 == `F3_ADD);
        end else if (opc == `OPC_OP_IMM) begin
            b   = {{(`XLEN-12){w[31]}}, w[31:20]};
            amt = w[25:20];
            ok  = (f3 != 3'b011);
            // immediate shifts only allow a 6-bit amount
            if (f3 == `F3_SLL || f3 == `F3_SRL) begin
                ok = ok && (w[31:26] == 6'd0);
            end
        end
        case (f3)
            `F3_ADD: res = (opc == `OPC_OP && f7 == `FUNCT7_ALT) ? a - b : a + b;
            `F3_SLL: res = a << amt;
            `F3_SLT: res = ($signed(a) < $signed(b)) ? `XLEN'(1) : '0;
            `F3_XOR: res = a ^ b;
            `F3_SRL: res = a >> amt;
            `F3_OR:  res = a | b;
            `F3_AND: res = a & b;
            default: res = '0;
        endcase
        wb.we    = ok && (rd != 5'd0);
        wb.waddr = rd;
        wb.wdata = res;
        if (wb.we) begin
            model_regs[rd] = res;
        end
        return wb;
    endfunction

    // ********************************************************
    // compare tasks
    // ********************************************************

    task automatic check_pc(input string name, input logic [`XLEN-1:0] actual,
                            input logic [`XLEN-1:0] expected);
        checks++;
        if (actual !== expected) begin
            errors++;
            $display("CHECK FAILED %s: got %h, expected %h", name, actual, expected);
        end
    endtask

    task automatic check_wb(input wb_t actual, input wb_t expected);
        checks++;
        if (actual.we !== expected.we) begin
            errors++;
            $display("CHECK FAILED wb_valid_o: got %h, expected %h", actual.we, expected.we);
        end else if (expected.we) begin
            if (actual.waddr !== expected.waddr) begin
                errors++;
                $display("CHECK FAILED wb_addr_o: got %h, expected %h",
                         actual.waddr, expected.waddr);
            end
            if (actual.wdata !== expected.wdata) begin
                errors++;
                $display("CHECK FAILED wb_data_o: got %h, expected %h",
                         actual.wdata, expected.wdata);
            end
        end
    endtask

    // ********************************************************
    // reset and program run
    // ********************************************************

    task automatic apply_reset();
        rst_n  = 1'b1;
        // a live instruction on the bus during reset must never retire
        inst_i = enc_i(`F3_ADD, 5'd31, 5'd0, 12'h7ff);
        repeat (RESET_CYCLES) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b0;
        // two cycles pass before the first writeback can show
        expect_q.delete();
        repeat (DRAIN_CYCLES) expect_q.push_back('0);
    endtask

    task automatic run_program(input string name);
        wb_t                actual;
        logic [`XLEN-1:0]   pc_exp;
        int                 err_before;
        err_before = errors;
        apply_reset();
        pc_exp = `XLEN'(`RESET_PC);
        for (int k = 0; k < prog_len + DRAIN_CYCLES; k++) begin
            check_pc("pc_o", pc_o, pc_exp);
            actual.we    = wb_valid_o;
            actual.waddr = wb_addr_o;
            actual.wdata = wb_data_o;
            check_wb(actual, expect_q.pop_front());
            inst_i = rom_word(pc_o);
            expect_q.push_back(predict(inst_i));
            pc_exp = pc_exp + `XLEN'(`PC_STEP);
            @(negedge clk);
        end
        $display("test %s finished with %0d errors", name, errors - err_before);
    endtask

    // ********************************************************
    // directed tests
    // ********************************************************

    // loads every register so later tests can read any of them
    task automatic reset_sequence();
        clear_rom();
        for (int n = 1; n < 32; n++) begin
            add_inst(enc_i(`F3_ADD, 5'(n), 5'd0, 12'(n * 397 - 2000)));
        end
        run_program("reset");
    endtask

    task automatic itype_alu();
        clear_rom();
        add_inst(enc_i(`F3_ADD, 5'd1, 5'd2, 12'd100));
        add_inst(enc_i(`F3_ADD, 5'd3, 5'd4, 12'h800));
        add_inst(enc_i(`F3_SLT, 5'd5, 5'd6, 12'd5));
        add_inst(enc_i(`F3_SLT, 5'd7, 5'd8, -12'sd1));
        add_inst(enc_i(`F3_XOR, 5'd9, 5'd10, -12'sd1));
        add_inst(enc_i(`F3_XOR, 5'd11, 5'd12, 12'h5a5));
        add_inst(enc_i(`F3_OR, 5'd13, 5'd14, -12'sd256));
        add_inst(enc_i(`F3_OR, 5'd15, 5'd16, 12'h0f0));
        add_inst(enc_i(`F3_AND, 5'd17, 5'd18, -12'sd16));
        add_inst(enc_i(`F3_AND, 5'd19, 5'd20, 12'h7ff));
        add_inst(enc_i(`F3_SLL, 5'd21, 5'd22, 12'd3));
        add_inst(enc_i(`F3_SLL, 5'd23, 5'd1, 12'd45));
        add_inst(enc_i(`F3_SRL, 5'd25, 5'd3, 12'd7));
        add_inst(enc_i(`F3_SRL, 5'd27, 5'd12, 12'd63));
        run_program("itype");
    endtask

    task automatic rtype_alu();
        clear_rom();
        add_inst(enc_i(`F3_ADD, 5'd30, 5'd0, 12'd40));
        add_inst(enc_i(`F3_ADD, 5'd31, 5'd0, 12'd33));
        add_inst(enc_r(`FUNCT7_BASE, `F3_ADD, 5'd1, 5'd2, 5'd3));
        add_inst(enc_r(`FUNCT7_ALT, `F3_ADD, 5'd4, 5'd5, 5'd6));
        add_inst(enc_r(`FUNCT7_ALT, `F3_ADD, 5'd7, 5'd6, 5'd5));
        add_inst(enc_r(`FUNCT7_BASE, `F3_SLL, 5'd8, 5'd9, 5'd30));
        add_inst(enc_r(`FUNCT7_BASE, `F3_SLT, 5'd12, 5'd2, 5'd6));
        add_inst(enc_r(`FUNCT7_BASE, `F3_SLT, 5'd14, 5'd6, 5'd2));
        add_inst(enc_r(`FUNCT7_BASE, `F3_XOR, 5'd16, 5'd17, 5'd18));
        add_inst(enc_r(`FUNCT7_BASE, `F3_SRL, 5'd19, 5'd3, 5'd31));
        add_inst(enc_r(`FUNCT7_BASE, `F3_SRL, 5'd20, 5'd21, 5'd30));
        add_inst(enc_r(`FUNCT7_BASE, `F3_OR, 5'd22, 5'd23, 5'd24));
        add_inst(enc_r(`FUNCT7_BASE, `F3_AND, 5'd26, 5'd27, 5'd28));
        run_program("rtype");
    endtask

    // each source is the rd of the instruction just before it
    task automatic dependency_chain();
        clear_rom();
        add_inst(enc_i(`F3_ADD, 5'd5, 5'd0, 12'd300));
        add_inst(enc_r(`FUNCT7_BASE, `F3_ADD, 5'd6, 5'd5, 5'd5));
        add_inst(enc_r(`FUNCT7_ALT, `F3_ADD, 5'd7, 5'd5, 5'd6));
        add_inst(enc_i(`F3_SLL, 5'd8, 5'd7, 12'd40));
        add_inst(enc_r(`FUNCT7_BASE, `F3_SRL, 5'd9, 5'd8, 5'd5));
        add_inst(enc_r(`FUNCT7_BASE, `F3_XOR, 5'd10, 5'd9, 5'd7));
        add_inst(enc_r(`FUNCT7_BASE, `F3_SLT, 5'd11, 5'd10, 5'd9));
        add_inst(enc_r(`FUNCT7_BASE, `F3_OR, 5'd12, 5'd11, 5'd7));
        add_inst(enc_r(`FUNCT7_BASE, `F3_AND, 5'd13, 5'd12, 5'd6));
        add_inst(enc_i(`F3_ADD, 5'd14, 5'd13, -12'sd1));
        add_inst(enc_r(`FUNCT7_BASE, `F3_SLL, 5'd15, 5'd14, 5'd14));
        run_program("dependencies");
    endtask

    task automatic suppressed_writes();
        clear_rom();
        add_inst(enc_i(`F3_ADD, 5'd0, 5'd1, 12'd123));
        add_inst(enc_r(`FUNCT7_BASE, `F3_ADD, 5'd0, 5'd2, 5'd3));
        add_inst(32'hffff_ffff);
        add_inst(32'h0000_0000);
        add_inst(enc_r(7'h01, `F3_ADD, 5'd4, 5'd5, 5'd6));
        add_inst(enc_r(`FUNCT7_ALT, `F3_XOR, 5'd4, 5'd5, 5'd6));
        add_inst(enc_i(3'b011, 5'd4, 5'd5, 12'd1));
        add_inst(enc_i(`F3_SRL, 5'd4, 5'd5, 12'h405));
        // x0 must still read as zero
        add_inst(enc_r(`FUNCT7_BASE, `F3_ADD, 5'd16, 5'd0, 5'd0));
        add_inst(enc_i(`F3_ADD, 5'd17, 5'd0, 12'd0));
        add_inst(enc_r(`FUNCT7_BASE, `F3_OR, 5'd18, 5'd0, 5'd0));
        run_program("no_write");
    endtask

    task automatic random_program();
        int             r;
        logic [2:0]     f3;
        logic [6:0]     f7;
        logic [11:0]    imm;
        clear_rom();
        for (int n = 0; n < RANDOM_COUNT; n++) begin
            r  = $random(seed);
            f3 = r[3:1];
            if (f3 == 3'b011) begin
                f3 = `F3_SLT;
            end
            if (r[0]) begin
                f7 = (f3 == `F3_ADD && r[4]) ? `FUNCT7_ALT : `FUNCT7_BASE;
                add_inst(enc_r(f7, f3, r[9:5], r[14:10], r[19:15]));
            end else begin
                imm = r[31:20];
                if (f3 == `F3_SLL || f3 == `F3_SRL) begin
                    imm = {6'd0, r[25:20]};
                end
                add_inst(enc_i(f3, r[9:5], r[14:10], imm));
            end
        end
        run_program("random");
    endtask

    initial begin
        rst_n  = 1'b1;
        inst_i = 32'h0;
        errors = 0;
        checks = 0;
        seed   = 32'h6e6d;
        for (int i = 0; i < 32; i++) begin
            model_regs[5'(i)] = '0;
        end
        reset_sequence();
        itype_alu();
        rtype_alu();
        dependency_chain();
        suppressed_writes();
        random_program();
        assert_fails = int'(dut0.chk0.fail_count);
        errors = errors + assert_fails;
        $display("tests: %0d, checks: %0d, assertion failures: %0d, errors: %0d",
                 NUM_TESTS, checks, assert_fails, errors);
        if (errors == 0) begin
            $display("Verification passed");
        end else begin
            $display("Verification failed");
        end
        $finish;
    end

endmodule
